// File: verilog.f
design/ex_cfg_pkg.sv
design/ex_op_pkg.sv
design/fu_issue_if.sv
design/alu.sv
design/branch_unit.sv
design/csr_buffer.sv
design/mult.sv
design/ex_stage.sv
verification/ex_stage_assert.sv
verification/tb_ex_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_ex_stage
FILELIST  := verilog.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: verification/tb_ex_stage.sv
// Random self-checking testbench for ex_stage at the default widths.
// Inputs change 1 ns after the rising edge, outputs are sampled 1 ns before the next one.
module tb_ex_stage import ex_cfg_pkg::*, ex_op_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned XLEN     = XLEN_DEFAULT;
    localparam int unsigned TID_BITS = TRANS_ID_BITS_DEFAULT;
    localparam int unsigned N_ALU    = 200;
    localparam int unsigned N_BR     = 200;
    localparam int unsigned N_CSR    = 20;
    localparam int unsigned N_MUL    = 100;
    localparam int unsigned N_FLUSH  = 10;
    // Mult rounds carry an extra ALU op, flush rounds a multiply and a CSR op
    localparam int unsigned N_OPS    = N_ALU + N_BR + N_CSR + 2 * N_MUL + 2 * N_FLUSH;

    logic clk_i, rst_ni, flush_i, is_compressed_i, predict_taken_i, csr_commit_i;
    logic alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i;
    fu_op_e operation_i;
    logic [XLEN-1:0] operand_a_i, operand_b_i, imm_i, pc_i, predict_target_i;
    logic [TID_BITS-1:0] trans_id_i, flu_trans_id_o;
    logic [XLEN-1:0] flu_result_o, branch_target_o;
    logic flu_valid_o, flu_ready_o, resolve_branch_o, branch_taken_o, branch_mispredict_o;
    csr_addr_t csr_addr_o;
    integer seed = 99848;

    ex_stage #(.XLEN(XLEN), .TRANS_ID_BITS(TID_BITS)) DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------
    // Random sources and model
    // ------------------------------
    function automatic int unsigned urand(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[XLEN-1:0];
    endfunction

    // Signed compare done by flipping the sign bits
    function automatic logic less_than(input logic [XLEN-1:0] a, b, input logic sgn);
        logic [XLEN-1:0] flip;
        flip = sgn ? {1'b1, {(XLEN-1){1'b0}}} : '0;
        return (a ^ flip) < (b ^ flip);
    endfunction

    function automatic logic [XLEN-1:0] model_alu(input fu_op_e op, input logic [XLEN-1:0] a, b);
        int unsigned sh;
        logic [2*XLEN-1:0] wide;
        sh = b % XLEN;
        wide = {{XLEN{a[XLEN-1]}}, a} >> sh;
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            XORL:    return a ^ b;
            ORL:     return a | b;
            ANDL:    return a & b;
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return wide[XLEN-1:0];
            SLTS:    return less_than(a, b, 1'b1) ? XLEN'(1) : '0;
            default: return less_than(a, b, 1'b0) ? XLEN'(1) : '0;
        endcase
    endfunction

    function automatic logic model_taken(input fu_op_e op, input logic [XLEN-1:0] a, b);
        case (op)
            EQ:      return a == b;
            NE:      return a != b;
            LTS:     return less_than(a, b, 1'b1);
            GES:     return !less_than(a, b, 1'b1);
            LTU:     return less_than(a, b, 1'b0);
            GEU:     return !less_than(a, b, 1'b0);
            default: return 1'b1;
        endcase
    endfunction

    // Full product modulo 2^(2*XLEN) of the extended operands
    function automatic logic [XLEN-1:0] model_product(input fu_op_e op, input logic [XLEN-1:0] a, b);
        logic [2*XLEN-1:0] ea, eb, p;
        ea = {{XLEN{(op == MULH || op == MULHSU) && a[XLEN-1]}}, a};
        eb = {{XLEN{(op == MULH) && b[XLEN-1]}}, b};
        p = ea * eb;
        return (op == MUL) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp, act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_id(input string name, input logic [TID_BITS-1:0] exp, act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input csr_addr_t exp, act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // Idle cycle with random issue data, so silencing gets exercised
    task automatic new_cycle();
        @(posedge clk_i);
        #1;
        {alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i} = '0;
        flush_i          = 1'b0;
        csr_commit_i     = 1'b0;
        operation_i      = fu_op_e'(5'(urand(22)));
        operand_a_i      = rand_word();
        operand_b_i      = rand_word();
        imm_i            = rand_word();
        trans_id_i       = TID_BITS'(urand(1 << TID_BITS));
        pc_i             = rand_word();
        is_compressed_i  = 1'(urand(2));
        predict_taken_i  = 1'(urand(2));
        predict_target_i = rand_word();
    endtask

    task automatic issue_alu();
        operation_i = fu_op_e'(5'(urand(10)));
        alu_valid_i = 1'b1;
        #2;
        check_word("alu result", model_alu(operation_i, operand_a_i, operand_b_i), flu_result_o);
        check_id("alu trans id", trans_id_i, flu_trans_id_o);
        check_flag("alu valid", 1'b1, flu_valid_o);
        check_flag("alu no resolve", 1'b0, resolve_branch_o);
    endtask

    task automatic issue_branch();
        logic taken;
        logic [XLEN-1:0] target, link;
        operation_i = fu_op_e'(5'(int'(EQ) + urand(7)));
        // Equal operands now and then, so EQ and GE get taken
        if (urand(4) == 0) operand_b_i = operand_a_i;
        taken  = model_taken(operation_i, operand_a_i, operand_b_i);
        target = (operation_i == JALR) ? ((operand_a_i + imm_i) & ~XLEN'(1)) : pc_i + imm_i;
        link   = pc_i + (is_compressed_i ? XLEN'(2) : XLEN'(4));
        if (urand(2) == 0) predict_target_i = target;
        branch_valid_i = 1'b1;
        #2;
        check_flag("branch resolve", 1'b1, resolve_branch_o);
        check_flag("branch taken", taken, branch_taken_o);
        check_word("branch target", target, branch_target_o);
        check_flag("branch mispredict",
                   (taken != predict_taken_i) || (taken && target != predict_target_i),
                   branch_mispredict_o);
        check_word("branch link", link, flu_result_o);
        check_id("branch trans id", trans_id_i, flu_trans_id_o);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [XLEN-1:0] exp_word;
        logic [TID_BITS-1:0] exp_id;
        csr_addr_t exp_addr;
        int unsigned hold;
        rst_ni = 1'b0;
        {alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i} = '0;
        {flush_i, csr_commit_i, is_compressed_i, predict_taken_i} = '0;
        operation_i = ADD;
        {operand_a_i, operand_b_i, imm_i, pc_i, predict_target_i} = '0;
        trans_id_i = '0;
        repeat (2) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        #2;
        check_flag("reset flu_valid", 1'b0, flu_valid_o);
        check_flag("reset resolve", 1'b0, resolve_branch_o);
        check_flag("reset ready", 1'b1, flu_ready_o);

        for (int i = 0; i < N_ALU; i++) begin
            new_cycle();
            issue_alu();
        end
        for (int i = 0; i < N_BR; i++) begin
            new_cycle();
            issue_branch();
        end

        // CSR held for a random time, then committed
        for (int i = 0; i < N_CSR; i++) begin
            new_cycle();
            operation_i = CSR_RW;
            csr_valid_i = 1'b1;
            exp_addr = imm_i[CSR_ADDR_BITS-1:0];
            #2;
            check_word("csr result", operand_a_i, flu_result_o);
            check_id("csr trans id", trans_id_i, flu_trans_id_o);
            check_flag("csr valid", 1'b1, flu_valid_o);
            hold = urand(4);
            for (int k = 0; k <= hold; k++) begin
                new_cycle();
                if (k == hold) csr_commit_i = 1'b1;
                #2;
                check_flag("csr ready held low", 1'b0, flu_ready_o);
                check_addr("csr address", exp_addr, csr_addr_o);
            end
            new_cycle();
            #2;
            check_flag("csr ready after commit", 1'b1, flu_ready_o);
        end

        // Multiply of each kind with an ALU op ahead of it
        for (int i = 0; i < N_MUL; i++) begin
            new_cycle();
            issue_alu();
            new_cycle();
            operation_i  = fu_op_e'(5'(int'(MUL) + i % 4));
            mult_valid_i = 1'b1;
            exp_word = model_product(operation_i, operand_a_i, operand_b_i);
            exp_id   = trans_id_i;
            #2;
            check_flag("mult issue cycle idle", 1'b0, flu_valid_o);
            new_cycle();
            #2;
            check_flag("mult valid", 1'b1, flu_valid_o);
            check_word("mult result", exp_word, flu_result_o);
            check_id("mult trans id", exp_id, flu_trans_id_o);
        end

        for (int i = 0; i < N_FLUSH; i++) begin
            new_cycle();
            operation_i  = fu_op_e'(5'(int'(MUL) + i % 4));
            mult_valid_i = 1'b1;
            new_cycle();
            flush_i = 1'b1;
            #2;
            check_flag("flushed mult result", 1'b0, flu_valid_o);
            new_cycle();
            operation_i = CSR_RW;
            csr_valid_i = 1'b1;
            new_cycle();
            flush_i = 1'b1;
            #2;
            check_flag("csr full before flush", 1'b0, flu_ready_o);
            new_cycle();
            #2;
            check_flag("csr ready after flush", 1'b1, flu_ready_o);
        end

        new_cycle();
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        repeat (N_OPS * 10) @(posedge clk_i);
        $display("Watchdog expired before the test sequence finished");
        abort_run();
    end

endmodule

// File: verification/ex_stage_assert.sv
// Protocol checks bound into every ex_stage instance.
// Checks start after the first reset, the ready check only until the first CSR issue.
module ex_stage_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic alu_valid_i,
    input logic branch_valid_i,
    input logic csr_valid_i,
    input logic mult_valid_i,
    // Registered multiply valid inside the stage
    input logic mult_res_valid_i,
    input logic flu_ready_i,
    input logic resolve_branch_i,
    input logic branch_taken_i,
    input logic mispredict_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic csr_issued_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            csr_issued_q <= 1'b0;
        end else if (csr_valid_i) begin
            csr_issued_q <= 1'b1;
        end
    end

    single_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i}))
        else $error("more than one unit valid in one cycle");

    // Write port belongs to the multiply result in its cycle
    port_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_res_valid_i |-> !(alu_valid_i || branch_valid_i || csr_valid_i))
        else $error("multiply result collides with a single-cycle issue");

    // No resolution flag may leak out without a branch issue
    resolve_only_on_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !branch_valid_i |-> !(resolve_branch_i || branch_taken_i || mispredict_i))
        else $error("branch resolved without a branch issue");

    ready_until_csr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !csr_issued_q |-> flu_ready_i)
        else $error("stage not ready before any CSR issue");

endmodule

bind ex_stage ex_stage_assert i_ex_stage_assert (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .alu_valid_i      (alu_valid_i),
    .branch_valid_i   (branch_valid_i),
    .csr_valid_i      (csr_valid_i),
    .mult_valid_i     (mult_valid_i),
    .mult_res_valid_i (mult_valid),
    .flu_ready_i      (flu_ready_o),
    .resolve_branch_i (resolve_branch_o),
    .branch_taken_i   (branch_taken_o),
    .mispredict_i     (branch_mispredict_o)
);

// File: design/ex_stage.sv
// Fixed-latency part of the execute stage: ALU, branch, CSR buffer, multiplier.
// Issuer must not send ALU, branch or CSR work in the cycle after a multiply.
module ex_stage import ex_cfg_pkg::*, ex_op_pkg::*; #(
    parameter int unsigned XLEN          = XLEN_DEFAULT,
    parameter int unsigned TRANS_ID_BITS = TRANS_ID_BITS_DEFAULT
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // Issue bundle
    input  fu_op_e                   operation_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  logic [XLEN-1:0]          operand_b_i,
    input  logic [XLEN-1:0]          imm_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    // Branch context
    input  logic [XLEN-1:0]          pc_i,
    input  logic                     is_compressed_i,
    input  logic                     predict_taken_i,
    input  logic [XLEN-1:0]          predict_target_i,
    // At most one per cycle
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic                     csr_valid_i,
    input  logic                     mult_valid_i,
    // Shared write-back port
    output logic [XLEN-1:0]          flu_result_o,
    output logic [TRANS_ID_BITS-1:0] flu_trans_id_o,
    output logic                     flu_valid_o,
    output logic                     flu_ready_o,
    // Branch resolution
    output logic                     resolve_branch_o,
    output logic                     branch_taken_o,
    output logic [XLEN-1:0]          branch_target_o,
    output logic                     branch_mispredict_o,
    // CSR
    output csr_addr_t                csr_addr_o,
    input  logic                     csr_commit_i
);

    logic                     alu_sel;
    logic                     alu_branch_res;
    logic [XLEN-1:0]          alu_result;
    logic [XLEN-1:0]          branch_link;
    logic [XLEN-1:0]          csr_result;
    logic                     csr_ready;
    logic [XLEN-1:0]          mult_result;
    logic                     mult_valid;
    logic [TRANS_ID_BITS-1:0] mult_trans_id;

    fu_issue_if #(.XLEN(XLEN), .TRANS_ID_BITS(TRANS_ID_BITS)) raw_if ();
    fu_issue_if #(.XLEN(XLEN), .TRANS_ID_BITS(TRANS_ID_BITS)) alu_if ();
    fu_issue_if #(.XLEN(XLEN), .TRANS_ID_BITS(TRANS_ID_BITS)) mult_if ();

    // ------------------------------
    // Operand silencing
    // ------------------------------
    // Branch and CSR take raw data, branch path is timing critical
    assign raw_if.operation = operation_i;
    assign raw_if.operand_a = operand_a_i;
    assign raw_if.operand_b = operand_b_i;
    assign raw_if.imm       = imm_i;
    assign raw_if.trans_id  = trans_id_i;

    // ALU also does the branch compare
    assign alu_sel           = alu_valid_i | branch_valid_i;
    assign alu_if.operation  = alu_sel ? operation_i : ADD;
    assign alu_if.operand_a  = alu_sel ? operand_a_i : '0;
    assign alu_if.operand_b  = alu_sel ? operand_b_i : '0;
    assign alu_if.imm        = alu_sel ? imm_i : '0;
    assign alu_if.trans_id   = alu_sel ? trans_id_i : '0;

    // Multiplier array toggles only on its own issues
    assign mult_if.operation = mult_valid_i ? operation_i : ADD;
    assign mult_if.operand_a = mult_valid_i ? operand_a_i : '0;
    assign mult_if.operand_b = mult_valid_i ? operand_b_i : '0;
    assign mult_if.imm       = mult_valid_i ? imm_i : '0;
    assign mult_if.trans_id  = mult_valid_i ? trans_id_i : '0;

    // ------------------------------
    // Units
    // ------------------------------
    alu #(.XLEN(XLEN)) i_alu (
        .issue        (alu_if),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    branch_unit #(.XLEN(XLEN)) i_branch_unit (
        .issue            (raw_if),
        .branch_valid_i   (branch_valid_i),
        .pc_i             (pc_i),
        .is_compressed_i  (is_compressed_i),
        .predict_taken_i  (predict_taken_i),
        .predict_target_i (predict_target_i),
        .branch_res_i     (alu_branch_res),
        .link_o           (branch_link),
        .resolve_o        (resolve_branch_o),
        .taken_o          (branch_taken_o),
        .target_o         (branch_target_o),
        .mispredict_o     (branch_mispredict_o)
    );

    csr_buffer #(.XLEN(XLEN)) i_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .issue        (raw_if),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    mult #(.XLEN(XLEN), .TRANS_ID_BITS(TRANS_ID_BITS)) i_mult (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .issue        (mult_if),
        .mult_valid_i (mult_valid_i),
        .result_o     (mult_result),
        .valid_o      (mult_valid),
        .trans_id_o   (mult_trans_id)
    );

    // ------------------------------
    // Write-back
    // ------------------------------
    // Branch link is the fallback, multiply carries its own ID
    always_comb begin
        flu_result_o   = branch_link;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            flu_result_o   = mult_result;
            flu_trans_id_o = mult_trans_id;
        end
    end

    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;
    // Multiplier never blocks, only a held CSR does
    assign flu_ready_o = csr_ready;

endmodule

// File: design/mult.sv
// Multiplier with one cycle of latency, never stalls.
// Flush kills the result of an issue in flight.
module mult import ex_cfg_pkg::*, ex_op_pkg::*; #(
    parameter int unsigned XLEN          = XLEN_DEFAULT,
    parameter int unsigned TRANS_ID_BITS = TRANS_ID_BITS_DEFAULT
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    fu_issue_if.unit                 issue,
    input  logic                     mult_valid_i,
    output logic [XLEN-1:0]          result_o,
    output logic                     valid_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o
);

    logic                     sign_a;
    logic                     sign_b;
    logic signed [XLEN:0]     opa_ext;
    logic signed [XLEN:0]     opb_ext;
    logic signed [2*XLEN+1:0] product;
    logic [XLEN-1:0]          word_d;
    logic [XLEN-1:0]          result_q;
    logic [TRANS_ID_BITS-1:0] trans_id_q;
    logic                     valid_q;

    // Operand signedness per operation, MUL low half is sign agnostic
    assign sign_a = issue.operation inside {MULH, MULHSU};
    assign sign_b = (issue.operation == MULH);

    // One extra bit turns every variant into a signed multiply
    assign opa_ext = {sign_a & issue.operand_a[XLEN-1], issue.operand_a};
    assign opb_ext = {sign_b & issue.operand_b[XLEN-1], issue.operand_b};
    assign product = opa_ext * opb_ext;

    assign word_d = (issue.operation == MUL) ? product[XLEN-1:0]
                                             : product[2*XLEN-1:XLEN];

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_q   <= word_d;
            trans_id_q <= issue.trans_id;
        end
    end

    assign result_o   = result_q;
    assign trans_id_o = trans_id_q;
    // A flush in the result cycle also drops it
    assign valid_o    = valid_q & ~flush_i;

endmodule

// File: design/csr_buffer.sv
// Single-entry CSR address buffer. Blocks further issue until commit or flush.
// The CSR value itself is read at commit, rs1 is forwarded as the result.
module csr_buffer import ex_cfg_pkg::*; #(
    parameter int unsigned XLEN = XLEN_DEFAULT
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    fu_issue_if.unit        issue,
    input  logic            csr_valid_i,
    input  logic            csr_commit_i,
    output logic            csr_ready_o,
    output logic [XLEN-1:0] csr_result_o,
    output csr_addr_t       csr_addr_o
);

    logic      full_q;
    csr_addr_t addr_q;

    // Entry occupancy
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i || csr_commit_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end
    end

    // Address comes from the immediate field of the CSR instruction
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= issue.imm[CSR_ADDR_BITS-1:0];
        end
    end

    assign csr_ready_o  = ~full_q;
    assign csr_addr_o   = addr_q;
    // Written back in the issue cycle
    assign csr_result_o = issue.operand_a;

endmodule

// File: design/branch_unit.sv
// Combinational branch resolution against the frontend prediction.
// Takes raw operands, the ALU supplies the comparison outcome.
module branch_unit import ex_cfg_pkg::*, ex_op_pkg::*; #(
    parameter int unsigned XLEN = XLEN_DEFAULT
) (
    fu_issue_if.unit        issue,
    input  logic            branch_valid_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            is_compressed_i,
    input  logic            predict_taken_i,
    input  logic [XLEN-1:0] predict_target_i,
    // From the ALU comparator
    input  logic            branch_res_i,
    output logic [XLEN-1:0] link_o,
    output logic            resolve_o,
    output logic            taken_o,
    output logic [XLEN-1:0] target_o,
    output logic            mispredict_o
);

    logic            is_jalr;
    logic [XLEN-1:0] target_base;
    logic [XLEN-1:0] target_sum;

    assign is_jalr = (issue.operation == JALR);

    // ------------------------------
    // Target
    // ------------------------------
    // JALR jumps relative to rs1, branches relative to their own PC
    assign target_base = is_jalr ? issue.operand_a : pc_i;
    assign target_sum  = target_base + issue.imm;
    // JALR clears the LSB as the ISA requires
    assign target_o    = is_jalr ? {target_sum[XLEN-1:1], 1'b0} : target_sum;

    // Return address for JALR, written back as the result
    assign link_o = pc_i + XLEN'(is_compressed_i ? CINSTR_BYTES : INSTR_BYTES);

    // ------------------------------
    // Resolution
    // ------------------------------
    assign resolve_o = branch_valid_i;
    assign taken_o   = branch_valid_i & is_branch_op(issue.operation) & branch_res_i;

    // Wrong direction, or right direction but wrong destination
    always_comb begin
        mispredict_o = 1'b0;
        if (branch_valid_i) begin
            if (taken_o != predict_taken_i) begin
                mispredict_o = 1'b1;
            end else if (taken_o && (target_o != predict_target_i)) begin
                mispredict_o = 1'b1;
            end
        end
    end

endmodule

// File: design/alu.sv
// Single-cycle integer ALU, purely combinational.
// Branch outcome is only meaningful for branch operations, JALR is always taken.
module alu import ex_cfg_pkg::*, ex_op_pkg::*; #(
    parameter int unsigned XLEN = XLEN_DEFAULT
) (
    fu_issue_if.unit          issue,
    output logic [XLEN-1:0]   result_o,
    output logic              branch_res_o
);

    localparam int unsigned SHAMT_BITS = $clog2(XLEN);

    logic [XLEN-1:0]       opa;
    logic [XLEN-1:0]       opb;
    logic [SHAMT_BITS-1:0] shamt;
    logic                  op_eq;
    logic                  op_lt;

    assign opa   = issue.operand_a;
    assign opb   = issue.operand_b;
    // Only the low bits of rs2 count for shifts
    assign shamt = opb[SHAMT_BITS-1:0];

    // ------------------------------
    // Shared comparator
    // ------------------------------
    assign op_eq = (opa == opb);
    // One less-than serves SLT and all ordered branches
    assign op_lt = is_signed_op(issue.operation) ? ($signed(opa) < $signed(opb))
                                                 : (opa < opb);

    // Branch decision
    always_comb begin
        branch_res_o = 1'b0;
        if (is_branch_op(issue.operation)) begin
            unique case (issue.operation)
                EQ:       branch_res_o = op_eq;
                NE:       branch_res_o = ~op_eq;
                LTS, LTU: branch_res_o = op_lt;
                GES, GEU: branch_res_o = ~op_lt;
                default:  branch_res_o = 1'b1;  // JALR
            endcase
        end
    end

    // ------------------------------
    // Result
    // ------------------------------
    always_comb begin
        result_o = '0;
        case (issue.operation)
            ADD:        result_o = opa + opb;
            SUB:        result_o = opa - opb;
            XORL:       result_o = opa ^ opb;
            ORL:        result_o = opa | opb;
            ANDL:       result_o = opa & opb;
            SLL:        result_o = opa << shamt;
            SRL:        result_o = opa >> shamt;
            // Arithmetic shift keeps the sign of rs1
            SRA:        result_o = $unsigned($signed(opa) >>> shamt);
            SLTS, SLTU: result_o = {{(XLEN-1){1'b0}}, op_lt};
            default:    result_o = '0;
        endcase
    end

endmodule

// File: design/fu_issue_if.sv
// Issue bundle shared by all fixed-latency units.
// One instance per silencing domain, driven by the stage only.
interface fu_issue_if import ex_cfg_pkg::*, ex_op_pkg::*; #(
    parameter int unsigned XLEN          = XLEN_DEFAULT,
    parameter int unsigned TRANS_ID_BITS = TRANS_ID_BITS_DEFAULT
) ();

    fu_op_e                   operation;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic [XLEN-1:0]          imm;
    // Scoreboard slot to write back to
    logic [TRANS_ID_BITS-1:0] trans_id;

    // Stage side
    modport issuer (output operation, operand_a, operand_b, imm, trans_id);

    // Functional unit side
    modport unit (input operation, operand_a, operand_b, imm, trans_id);

endinterface

// File: design/ex_op_pkg.sv
// Operations of the fixed-latency units, encoded in 5 bits.
// ADD encodes as zero, so a silenced bundle reads as a harmless add.
package ex_op_pkg;

    typedef enum logic [4:0] {
        // ALU
        ADD = 5'd0, SUB, XORL, ORL, ANDL,
        SLL, SRL, SRA, SLTS, SLTU,
        // Branch comparisons and register jump
        EQ, NE, LTS, GES, LTU, GEU, JALR,
        // Multiplier
        MUL, MULH, MULHU, MULHSU,
        // CSR access
        CSR_RW
    } fu_op_e;

    // ------------------------------
    // Classification
    // ------------------------------
    // Conditional branches plus JALR
    function automatic logic is_branch_op(input fu_op_e op);
        return op inside {EQ, NE, LTS, GES, LTU, GEU, JALR};
    endfunction

    // Compares that treat operands as two's complement
    function automatic logic is_signed_op(input fu_op_e op);
        return op inside {SLTS, LTS, GES};
    endfunction

endpackage

// File: design/ex_cfg_pkg.sv
// Default widths for the execute stage. The top level overrides them through
// its parameters. CSR address width is fixed by the ISA.
package ex_cfg_pkg;

    // ------------------------------
    // Datapath defaults
    // ------------------------------
    // Data and PC width, RV32 by default
    localparam int unsigned XLEN_DEFAULT = 32;

    // Scoreboard entry ID width
    localparam int unsigned TRANS_ID_BITS_DEFAULT = 3;

    // ------------------------------
    // ISA constants
    // ------------------------------
    // Zicsr address field
    localparam int unsigned CSR_ADDR_BITS = 12;

    // Link address increments
    localparam int unsigned INSTR_BYTES  = 4;
    localparam int unsigned CINSTR_BYTES = 2;

    // Buffered CSR address as seen by commit
    typedef logic [CSR_ADDR_BITS-1:0] csr_addr_t;

endpackage
